/* Makefile */
VERILATOR ?= verilator
TOP       ?= resultPathTb
FILELIST  ?= resultPath.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/100ps
PASS_TEXT ?= ** PASS **

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass message
run: compile
	@out="$$($(abspath $(SIM)) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* dv/clockGen.sv */
`timescale 1ns/100ps

module clockGen #(
    parameter int HalfPeriod  = 10,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic globalreset
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #HalfPeriod clk = ~clk;
        end
    end

    initial
    begin
        globalreset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        globalreset = 1'b0;     // Released on a falling edge
    end

endmodule

/* dv/resultPathTb.sv */
`timescale 1ns/100ps

module resultPathTb;

    import rayResultPkg::*;

    localparam int NumTests   = 6;
    localparam int FrameBound = 20;

    logic        clk;
    logic        globalreset;
    logic        valid01;
    logic        valid10;
    resultSetT   result01;
    resultSetT   result10;
    logic        cfgWrite;
    cfgT         cfgData;
    logic [31:0] resultData;
    logic        resultReady;
    sourceT      resultSource;
    logic        overrun01;
    logic        overrun10;

    logic [31:0] rngState    = 32'haac9_180a;
    int          errorCount  = 0;
    int          failedTests = 0;
    int          testErrors  = 0;

    clockGen i_clock (
        .clk         (clk),
        .globalreset (globalreset)
    );

    resultPath #(
        .ResetRoundRobin(1'b0)
    ) i_dut (
        .clk          (clk),
        .globalreset  (globalreset),
        .valid01      (valid01),
        .valid10      (valid10),
        .result01     (result01),
        .result10     (result10),
        .cfgWrite     (cfgWrite),
        .cfgData      (cfgData),
        .resultData   (resultData),
        .resultReady  (resultReady),
        .resultSource (resultSource),
        .overrun01    (overrun01),
        .overrun10    (overrun10)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic makeSet(output resultSetT s);
        logic [159:0] bits;
        bits = '0;
        for (int i = 0; i < 5; i++)
        begin
            rngState = xorshift(rngState);
            bits = {bits[127:0], rngState};
        end
        s = bits[146:0];
    endtask

    // Word layout built field by field with shifts
    function automatic logic [31:0] expectedWord(input resultSetT s, input int index);
        case (index)
            0: return (32'(s.idA) << 16) | 32'(s.idB);
            1: return (32'(s.hitA) << 18) | (32'(s.hitB) << 17) | (32'(s.hitC) << 16)
                   | 32'(s.idC);
            2: return (32'(s.uA >> 8) << 16) | (32'(s.uB >> 8) << 8) | 32'(s.uC >> 8);
            default: return (32'(s.vA >> 8) << 16) | (32'(s.vB >> 8) << 8) | 32'(s.vC >> 8);
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
            errorCount++;
        end
    endtask

    // Called on a falling edge, returns on the next one with valid low
    task automatic strobe(input logic on01, input logic on10,
                          input resultSetT s01, input resultSetT s10);
        valid01  = on01;
        valid10  = on10;
        result01 = s01;
        result10 = s10;
        @(negedge clk);
        valid01 = 1'b0;
        valid10 = 1'b0;
    endtask

    task automatic writeConfig(input cfgT value);
        cfgData  = value;
        cfgWrite = 1'b1;
        @(negedge clk);
        cfgWrite = 1'b0;
        @(negedge clk);
    endtask

    task automatic receiveFrame(output logic [3:0][31:0] words, output sourceT source,
                                output int latency);
        latency = 0;
        words   = '0;
        source  = SrcNone;
        while (!resultReady && latency < FrameBound)
        begin
            @(negedge clk);
            latency++;
        end
        if (!resultReady)
        begin
            $display("No frame started within %0d cycles", FrameBound);
            errorCount++;
        end
        else
        begin
            words[0] = resultData;
            source   = resultSource;
            for (int i = 1; i < 4; i++)
            begin
                @(negedge clk);
                words[i] = resultData;
                checkValue("resultReady", 32'(resultReady), 32'd0);
                checkValue("resultSource", 32'(resultSource), 32'(source));
            end
        end
    endtask

    // A latency of 0 skips the latency check
    task automatic expectFrame(input resultSetT s, input sourceT src, input int latencyWanted);
        logic [3:0][31:0] words;
        sourceT           source;
        int               latency;
        receiveFrame(words, source, latency);
        if (latencyWanted > 0)
        begin
            checkValue("latency", latency, latencyWanted);
        end
        checkValue("resultSource", 32'(source), 32'(src));
        for (int i = 0; i < 4; i++)
        begin
            checkValue($sformatf("resultData word %0d", i), words[i], expectedWord(s, i));
        end
    endtask

    task automatic expectQuiet(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            if (resultReady)
            begin
                $display("A frame appeared where none was expected");
                errorCount++;
            end
        end
    endtask

    task automatic finishTest(input int number, input string name);
        if (errorCount == testErrors)
        begin
            $display("Test %0d %s: passed", number, name);
        end
        else
        begin
            $display("Test %0d %s: failed", number, name);
            failedTests++;
        end
        testErrors = errorCount;
    endtask

    task automatic testSingle01();
        resultSetT s;
        makeSet(s);
        strobe(1'b1, 1'b0, s, '0);
        expectFrame(s, Src01, 2);
        finishTest(1, "single set on channel 01");
    endtask

    task automatic testSingle10();
        resultSetT s;
        makeSet(s);
        strobe(1'b0, 1'b1, '0, s);
        expectFrame(s, Src10, 2);
        finishTest(2, "single set on channel 10");
    endtask

    task automatic testFixedPriority();
        resultSetT a;
        resultSetT b;
        makeSet(a);
        makeSet(b);
        strobe(1'b1, 1'b1, a, b);
        expectFrame(a, Src01, 2);
        expectFrame(b, Src10, 0);
        finishTest(3, "fixed priority");
    endtask

    task automatic testRoundRobin();
        resultSetT a;
        resultSetT b;
        resultSetT c;
        writeConfig('{enable01: 1'b1, enable10: 1'b1, roundRobin: 1'b1});
        for (int round = 0; round < 3; round++)
        begin
            makeSet(a);
            makeSet(b);
            strobe(1'b1, 1'b1, a, b);
            expectFrame(a, Src01, 0);
            expectFrame(b, Src10, 0);
        end
        // A lone 01 frame leaves channel 10 to win the next tie
        makeSet(c);
        makeSet(a);
        makeSet(b);
        strobe(1'b1, 1'b0, c, '0);
        strobe(1'b1, 1'b1, a, b);
        expectFrame(c, Src01, 0);
        expectFrame(b, Src10, 0);
        expectFrame(a, Src01, 0);
        finishTest(4, "round robin");
    endtask

    task automatic testDisabled();
        resultSetT s;
        writeConfig('{enable01: 1'b1, enable10: 1'b0, roundRobin: 1'b1});
        makeSet(s);
        repeat (3) strobe(1'b0, 1'b1, '0, s);   // Would overrun if enabled
        expectQuiet(20);
        checkValue("overrun10", 32'(overrun10), 32'd0);
        writeConfig(CfgResetDefault);
        finishTest(5, "disabled channel 10");
    endtask

    task automatic testOverrun();
        resultSetT a;
        resultSetT b;
        resultSetT c;
        makeSet(a);
        makeSet(b);
        makeSet(c);
        checkValue("overrun01", 32'(overrun01), 32'd0);
        strobe(1'b1, 1'b0, a, '0);
        strobe(1'b1, 1'b0, b, '0);
        strobe(1'b1, 1'b0, c, '0);
        expectFrame(a, Src01, 0);
        expectFrame(b, Src01, 0);
        checkValue("overrun01", 32'(overrun01), 32'd1);
        expectQuiet(20);
        checkValue("overrun01", 32'(overrun01), 32'd1);
        finishTest(6, "overrun on channel 01");
    endtask

    initial
    begin
        valid01  = 1'b0;
        valid10  = 1'b0;
        result01 = '0;
        result10 = '0;
        cfgWrite = 1'b0;
        cfgData  = CfgResetDefault;
        @(negedge globalreset);
        @(negedge clk);
        testSingle01();
        testSingle10();
        testFixedPriority();
        testRoundRobin();
        testDisabled();
        testOverrun();
        if (i_dut.i_chk.failCount != 0)
        begin
            $display("Bound checker saw %0d assertion failures", i_dut.i_chk.failCount);
            errorCount += i_dut.i_chk.failCount;
        end
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 NumTests, failedTests, errorCount);
        if (errorCount == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial
    begin
        repeat (NumTests * 200) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run stopped", NumTests * 200);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* dv/resultPath_chk.sv */
`timescale 1ns/100ps

module resultPathChk (
    input logic                 clk,
    input logic                 globalreset,
    input logic                 resultReady,
    input rayResultPkg::sourceT resultSource
);

    import rayResultPkg::*;

    int failCount = 0;

    // A frame always names its channel
    sourceNamed: assert property (@(posedge clk) disable iff (globalreset)
        resultReady |-> resultSource != SrcNone)
        else
        begin
            $error("resultReady high with resultSource SrcNone");
            failCount++;
        end

    // Words 1 to 3 follow with ready low and an unchanged source
    frameTail: assert property (@(posedge clk) disable iff (globalreset)
        ($past(resultReady, 1) || $past(resultReady, 2) || $past(resultReady, 3))
            |-> (!resultReady && $stable(resultSource)))
        else
        begin
            $error("resultReady or resultSource changed inside a frame");
            failCount++;
        end

    noDoubleReady: assert property (@(posedge clk) disable iff (globalreset)
        resultReady |=> !resultReady)
        else
        begin
            $error("resultReady high in two consecutive cycles");
            failCount++;
        end

endmodule

bind resultPath resultPathChk i_chk (
    .clk          (clk),
    .globalreset  (globalreset),
    .resultReady  (resultReady),
    .resultSource (resultSource)
);

/* logic/rayResultPkg.sv */
package rayResultPkg;

    // One channel's result for three rays
    typedef struct packed {
        logic [15:0] idA;
        logic [15:0] idB;
        logic [15:0] idC;
        logic        hitA;
        logic        hitB;
        logic        hitC;
        logic [15:0] uA;
        logic [15:0] uB;
        logic [15:0] uC;
        logic [15:0] vA;
        logic [15:0] vB;
        logic [15:0] vC;
    } resultSetT;

    // Source code on the result port
    typedef enum logic [1:0] {
        SrcNone = 2'd0,
        Src01   = 2'd1,
        Src10   = 2'd2
    } sourceT;

    typedef struct packed {
        logic enable01;
        logic enable10;
        logic roundRobin;   // 0 is fixed priority, channel 01 first
    } cfgT;

    localparam cfgT CfgResetDefault = '{
        enable01:   1'b1,
        enable10:   1'b1,
        roundRobin: 1'b0
    };

endpackage

/* logic/resultCapture.sv */
`timescale 1ns/100ps

module resultCapture (
    input  logic                   clk,
    input  logic                   globalreset,
    input  logic                   enable,
    input  logic                   valid,
    input  rayResultPkg::resultSetT result,
    input  logic                   take,
    output logic                   pending,
    output rayResultPkg::resultSetT heldSet,
    output logic                   overrun
);

    logic accept;
    logic drop;

    // A take in the same cycle frees the holding register
    assign accept = enable && valid && (!pending || take);
    assign drop   = enable && valid && pending && !take;

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            pending <= 1'b0;
            overrun <= 1'b0;
        end
        else
        begin
            if (accept)
            begin
                pending <= 1'b1;
            end
            else if (take)
            begin
                pending <= 1'b0;
            end

            if (drop)
            begin
                overrun <= 1'b1;    // Sticky until reset
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            heldSet <= result;
        end
    end

endmodule

/* logic/resultConfig.sv */
`timescale 1ns/100ps

module resultConfig #(
    parameter bit ResetRoundRobin = 1'b0
) (
    input  logic             clk,
    input  logic             globalreset,
    input  logic             cfgWrite,
    input  rayResultPkg::cfgT cfgData,
    output rayResultPkg::cfgT cfg
);

    import rayResultPkg::*;

    // Default enables, arbitration mode from the top level
    localparam cfgT ResetCfg = '{
        enable01:   CfgResetDefault.enable01,
        enable10:   CfgResetDefault.enable10,
        roundRobin: ResetRoundRobin
    };

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            cfg <= ResetCfg;
        end
        else if (cfgWrite)
        begin
            cfg <= cfgData;     // Seen by captures and arbiter next cycle
        end
    end

endmodule

/* logic/resultPath.sv */
`timescale 1ns/100ps

module resultPath #(
    parameter bit ResetRoundRobin = 1'b0
) (
    input  logic                    clk,
    input  logic                    globalreset,
    input  logic                    valid01,
    input  logic                    valid10,
    input  rayResultPkg::resultSetT result01,
    input  rayResultPkg::resultSetT result10,
    input  logic                    cfgWrite,
    input  rayResultPkg::cfgT       cfgData,
    output logic [31:0]             resultData,
    output logic                    resultReady,
    output rayResultPkg::sourceT    resultSource,
    output logic                    overrun01,
    output logic                    overrun10
);

    import rayResultPkg::*;

    cfgT       cfg;
    logic      pending01;
    logic      pending10;
    resultSetT heldSet01;
    resultSetT heldSet10;
    logic      take01;
    logic      take10;

    resultConfig #(
        .ResetRoundRobin(ResetRoundRobin)
    ) i_config (
        .clk         (clk),
        .globalreset (globalreset),
        .cfgWrite    (cfgWrite),
        .cfgData     (cfgData),
        .cfg         (cfg)
    );

    resultCapture i_capture01 (
        .clk         (clk),
        .globalreset (globalreset),
        .enable      (cfg.enable01),
        .valid       (valid01),
        .result      (result01),
        .take        (take01),
        .pending     (pending01),
        .heldSet     (heldSet01),
        .overrun     (overrun01)
    );

    resultCapture i_capture10 (
        .clk         (clk),
        .globalreset (globalreset),
        .enable      (cfg.enable10),
        .valid       (valid10),
        .result      (result10),
        .take        (take10),
        .pending     (pending10),
        .heldSet     (heldSet10),
        .overrun     (overrun10)
    );

    resultTransmit i_transmit (
        .clk          (clk),
        .globalreset  (globalreset),
        .roundRobin   (cfg.roundRobin),
        .pending01    (pending01),
        .pending10    (pending10),
        .set01        (heldSet01),
        .set10        (heldSet10),
        .take01       (take01),
        .take10       (take10),
        .resultData   (resultData),
        .resultReady  (resultReady),
        .resultSource (resultSource)
    );

endmodule

/* logic/resultTransmit.sv */
`timescale 1ns/100ps

module resultTransmit (
    input  logic                    clk,
    input  logic                    globalreset,
    input  logic                    roundRobin,
    input  logic                    pending01,
    input  logic                    pending10,
    input  rayResultPkg::resultSetT set01,
    input  rayResultPkg::resultSetT set10,
    output logic                    take01,
    output logic                    take10,
    output logic [31:0]             resultData,
    output logic                    resultReady,
    output rayResultPkg::sourceT    resultSource
);

    import rayResultPkg::*;

    typedef enum logic [2:0] {
        Idle,
        Word0,
        Word1,
        Word2,
        Word3
    } stateT;

    stateT       state;
    resultSetT   txSet;
    sourceT      txSource;
    logic        lastWas10;
    logic        pick01;
    logic [31:0] nextWord;

    // Arbitration, only matters when both channels wait
    always_comb
    begin
        pick01 = pending01;
        if (pending01 && pending10)
        begin
            pick01 = !roundRobin || lastWas10;
        end
    end

    assign take01 = (state == Idle) && pending01 && pick01;
    assign take10 = (state == Idle) && pending10 && !pick01;

    // Copy of the winning set, sent while the capture takes the next one
    always_ff @(posedge clk)
    begin
        if (take01 || take10)
        begin
            txSet    <= take01 ? set01 : set10;
            txSource <= take01 ? Src01 : Src10;
        end
    end

    always_comb
    begin
        case (state)
            Word0:
                nextWord = {txSet.idA, txSet.idB};
            Word1:
                nextWord = {13'd0, txSet.hitA, txSet.hitB, txSet.hitC, txSet.idC};
            Word2:
                nextWord = {8'd0, txSet.uA[15:8], txSet.uB[15:8], txSet.uC[15:8]};
            default:
                nextWord = {8'd0, txSet.vA[15:8], txSet.vB[15:8], txSet.vC[15:8]};
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (globalreset)
        begin
            state        <= Idle;
            lastWas10    <= 1'b1;   // So channel 01 wins the first tie in round robin
            resultData   <= '0;
            resultReady  <= 1'b0;
            resultSource <= SrcNone;
        end
        else
        begin
            resultReady <= 1'b0;

            case (state)
                Idle:
                begin
                    if (take01 || take10)
                    begin
                        state     <= Word0;
                        lastWas10 <= take10;
                    end
                end
                Word0:
                    state <= Word1;
                Word1:
                    state <= Word2;
                Word2:
                    state <= Word3;
                default:
                    state <= Idle;
            endcase

            // Outputs hold their last values between frames
            if (state != Idle)
            begin
                resultData   <= nextWord;
                resultSource <= txSource;
                resultReady  <= (state == Word0);
            end
        end
    end

endmodule

/* resultPath.f */
logic/rayResultPkg.sv
logic/resultCapture.sv
logic/resultConfig.sv
logic/resultTransmit.sv
logic/resultPath.sv
dv/clockGen.sv
dv/resultPath_chk.sv
dv/resultPathTb.sv
